// File: axil_mem_top.f
rtl/axil_mem_pkg.sv
rtl/axil_addr_check.sv
rtl/axil_sram_bank.sv
rtl/axil_mem_ctrl.sv
rtl/axil_mem_top.sv
dv/axil_mem_clkgen.sv
dv/axil_mem_tb.sv

// File: dv/axil_mem_clkgen.sv
// Testbench clock and reset source; 8 ns clock, reset held high for the first 4 rising edges
`timescale 1ns/1ps
`default_nettype none

module axil_mem_clkgen (
  output logic o_aclk,
  output logic o_rst
);

  // 125 MHz
  initial begin
    o_aclk = 1'b0;
    forever #4 o_aclk = ~o_aclk;
  end

  // Synchronous release after 4 cycles
  initial begin
    o_rst = 1'b1;
    repeat (4) @(posedge o_aclk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/axil_mem_tb.sv
// Testbench for the AXI4-Lite data memory; top module axil_mem_tb, compiled with axil_mem_top.f
`timescale 1ns/1ps
`default_nettype none

module axil_mem_tb import axil_mem_pkg::*; ();

  localparam int WAIT_LIMIT = 200;

  typedef enum int {
    SIG_RST_DONE, SIG_AWREADY, SIG_WREADY, SIG_BVALID, SIG_ARREADY, SIG_RVALID
  } hs_sig_e;

  logic                   aclk;
  logic                   rst;
  logic                   awvalid;
  logic                   awready;
  logic [AXIL_ADDR_W-1:0] awaddr;
  logic [AXIL_PROT_W-1:0] awprot;
  logic                   wvalid;
  logic                   wready;
  logic [AXIL_DATA_W-1:0] wdata;
  logic [AXIL_STRB_W-1:0] wstrb;
  logic                   bvalid;
  logic                   bready;
  logic [1:0]             bresp;
  logic                   arvalid;
  logic                   arready;
  logic [AXIL_ADDR_W-1:0] araddr;
  logic [AXIL_PROT_W-1:0] arprot;
  logic                   rvalid;
  logic                   rready;
  logic [AXIL_DATA_W-1:0] rdata;
  logic [1:0]             rresp;

  // Reference model state
  logic [AXIL_DATA_W-1:0] shadow [MEM_WORDS];
  axil_resp_e             exp_bresp;
  axil_resp_e             exp_rresp;
  logic [AXIL_DATA_W-1:0] exp_rdata;
  logic [MEM_IDX_W-1:0]   awaddr_q_idx;

  int value_errors;
  int protocol_errors;
  int timeouts;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;
  assign ar_fire = arvalid && arready;

  axil_mem_clkgen u_clkgen (
    .o_aclk (aclk),
    .o_rst  (rst)
  );

  axil_mem_top axil_mem_top_inst (
    .i_aclk (aclk),       .i_rst (rst),
    .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr), .i_awprot (awprot),
    .i_wvalid (wvalid),   .o_wready (wready),   .i_wdata (wdata),   .i_wstrb (wstrb),
    .o_bvalid (bvalid),   .i_bready (bready),   .o_bresp (bresp),
    .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr), .i_arprot (arprot),
    .o_rvalid (rvalid),   .i_rready (rready),   .o_rdata (rdata),   .o_rresp (rresp)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  // 2 KiB window from the base with its top quarter gated by prot[0]
  function automatic axil_resp_e expected_resp(input logic [31:0] addr, input logic [2:0] prot);
    if (addr < MEM_BASE || addr >= MEM_BASE + 32'(8 * MEM_WORDS)) begin
      return DECERR;
    end
    if (addr >= MEM_PRIV_BASE && !prot[0]) begin
      return SLVERR;
    end
    return OKAY;
  endfunction

  function automatic logic [31:0] word_addr(input int idx);
    return MEM_BASE + 32'(idx * 8);
  endfunction

  // Read sampled before the write merge, so a same-edge collision sees old data
  always @(posedge aclk) begin : model
    axil_resp_e rd_resp;
    if (ar_fire) begin
      rd_resp = expected_resp(araddr, arprot);
      exp_rresp <= rd_resp;
      exp_rdata <= (rd_resp == OKAY) ? shadow[araddr[10:3]] : '0;
    end
    if (w_fire && exp_bresp == OKAY) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (wstrb[b]) begin
          shadow[awaddr_q_idx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    if (aw_fire) begin
      exp_bresp    <= expected_resp(awaddr, awprot);
      awaddr_q_idx <= awaddr[10:3];
    end
  end

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    value_errors++;
    $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
  endtask

  task automatic report_protocol(input string what);
    protocol_errors++;
    $display("Protocol error at %0t: %s", $time, what);
  endtask

  task automatic finish_run();
    $display("Errors: value %0d, protocol %0d, timeout %0d",
      value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // ------------------------------
  // Assertions
  // ------------------------------
  a_reset_values: assert property (@(posedge aclk)
      $past(rst) |-> ({awready, arready, wready, bvalid, rvalid} == 5'b11000))
    else report_value("awready,arready,wready,bvalid,rvalid", 64'(5'b11000),
      64'($sampled({awready, arready, wready, bvalid, rvalid})));

  a_aw_to_w: assert property (@(posedge aclk) disable iff (rst)
      aw_fire |=> (wready && !awready))
    else report_protocol("wready did not replace awready after the AW handshake");

  a_w_to_b: assert property (@(posedge aclk) disable iff (rst) w_fire |=> bvalid)
    else report_protocol("bvalid did not rise in the cycle after the W handshake");

  a_b_done: assert property (@(posedge aclk) disable iff (rst) b_fire |=> awready)
    else report_protocol("awready did not return after the B handshake");

  a_ar_to_r: assert property (@(posedge aclk) disable iff (rst) ar_fire |=> rvalid)
    else report_protocol("rvalid did not rise in the cycle after the AR handshake");

  a_aw_blocked: assert property (@(posedge aclk) disable iff (rst)
      (wready || bvalid) |-> !awready)
    else report_protocol("awready high while a write was in flight");

  a_ar_blocked: assert property (@(posedge aclk) disable iff (rst) rvalid |-> !arready)
    else report_protocol("arready high while rvalid was pending");

  a_bresp: assert property (@(posedge aclk) disable iff (rst) bvalid |-> (bresp == exp_bresp))
    else report_value("bresp", 64'($sampled(exp_bresp)), 64'($sampled(bresp)));

  a_rresp: assert property (@(posedge aclk) disable iff (rst) rvalid |-> (rresp == exp_rresp))
    else report_value("rresp", 64'($sampled(exp_rresp)), 64'($sampled(rresp)));

  a_rdata: assert property (@(posedge aclk) disable iff (rst) rvalid |-> (rdata == exp_rdata))
    else report_value("rdata", $sampled(exp_rdata), $sampled(rdata));

  a_b_hold: assert property (@(posedge aclk) disable iff (rst)
      (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else report_protocol("write response changed while bready was low");

  a_r_hold: assert property (@(posedge aclk) disable iff (rst)
      (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else report_protocol("read response changed while rready was low");

  // ------------------------------
  // Stimulus
  // ------------------------------
  function automatic logic sig_level(input hs_sig_e which);
    case (which)
      SIG_RST_DONE: return !rst;
      SIG_AWREADY:  return awready;
      SIG_WREADY:   return wready;
      SIG_BVALID:   return bvalid;
      SIG_ARREADY:  return arready;
      default:      return rvalid;
    endcase
  endfunction

  // Returns on the first edge where the signal was high before the edge
  task automatic wait_high(input hs_sig_e which);
    int cycles;
    cycles = 0;
    @(posedge aclk);
    while (!sig_level(which) && cycles < WAIT_LIMIT) begin
      @(posedge aclk);
      cycles++;
    end
    if (!sig_level(which)) begin
      timeouts++;
      $display("Timeout at %0t waiting for %s", $time, which.name());
      finish_run();
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [2:0] prot,
                            input logic [63:0] data, input logic [7:0] strb, input int bp);
    awvalid <= 1'b1;
    awaddr  <= addr;
    awprot  <= prot;
    wait_high(SIG_AWREADY);
    awvalid <= 1'b0;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wait_high(SIG_WREADY);
    wvalid <= 1'b0;
    wait_high(SIG_BVALID);
    repeat (bp) @(posedge aclk);
    bready <= 1'b1;
    wait_high(SIG_BVALID);
    bready <= 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, input logic [2:0] prot, input int bp);
    arvalid <= 1'b1;
    araddr  <= addr;
    arprot  <= prot;
    wait_high(SIG_ARREADY);
    arvalid <= 1'b0;
    wait_high(SIG_RVALID);
    repeat (bp) @(posedge aclk);
    rready <= 1'b1;
    wait_high(SIG_RVALID);
    rready <= 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] addr;
    logic [63:0] data;
    int          idx;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    awvalid = 1'b0;
    awaddr  = '0;
    awprot  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arprot  = '0;
    rready  = 1'b0;
    void'($urandom(32'h9354_b9b8));
    wait_high(SIG_RST_DONE);

    // Fill every word so the model and the SRAM start equal
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr = word_addr(i);
      write_word(addr, 3'b001, {~addr, addr}, 8'hff, 0);
    end

    // Unprivileged round trips with random then full strobes
    repeat (48) begin
      idx  = $urandom_range(191, 0);
      data = {$urandom, $urandom};
      write_word(word_addr(idx), 3'b000, data, 8'($urandom), $urandom_range(4, 0));
      read_word(word_addr(idx), 3'b000, $urandom_range(4, 0));
      write_word(word_addr(idx), 3'b000, ~data, 8'hff, 0);
      read_word(word_addr(idx), 3'b000, 0);
    end

    // Below and above the window, each followed by a read of the aliased word
    repeat (8) begin
      addr = 32'($urandom) & 32'h7fff_fff8;
      write_word(addr, 3'b001, {$urandom, $urandom}, 8'hff, 1);
      read_word(addr, 3'b001, 1);
      read_word(word_addr(int'(addr[10:3])), 3'b001, 0);
      addr = 32'h8000_0800 + (32'($urandom) & 32'h3fff_fff8);
      write_word(addr, 3'b001, {$urandom, $urandom}, 8'hff, 1);
      read_word(addr, 3'b001, 1);
      read_word(word_addr(int'(addr[10:3])), 3'b001, 0);
    end

    // Privileged quarter without and with prot[0]
    repeat (12) begin
      idx  = $urandom_range(255, 192);
      data = {$urandom, $urandom};
      write_word(word_addr(idx), {2'($urandom), 1'b0}, data, 8'hff, 0);
      read_word(word_addr(idx), {2'($urandom), 1'b0}, 0);
      read_word(word_addr(idx), 3'b001, 0);
      write_word(word_addr(idx), 3'b001, data, 8'($urandom), 0);
      read_word(word_addr(idx), 3'b001, 0);
    end

    // Long back-pressure on both response channels
    repeat (10) begin
      idx = $urandom_range(255, 0);
      write_word(word_addr(idx), 3'b001, {$urandom, $urandom}, 8'hff, $urandom_range(12, 3));
      read_word(word_addr(idx), 3'b001, $urandom_range(12, 3));
    end

    // Read and write of one word firing on the same edge
    repeat (4) begin
      idx = $urandom_range(191, 0);
      fork
        write_word(word_addr(idx), 3'b000, {$urandom, $urandom}, 8'hff, 0);
        begin
          @(posedge aclk);
          read_word(word_addr(idx), 3'b000, 0);
        end
      join
      read_word(word_addr(idx), 3'b000, 0);
    end

    repeat (4) @(posedge aclk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: rtl/axil_addr_check.sv
// Combinational address decode; maps an AW/AR request to an SRAM word index and an AXI response
`timescale 1ns/1ps
`default_nettype none

module axil_addr_check import axil_mem_pkg::*; (
  input  wire axil_req_t i_req,
  output addr_dec_t      o_dec
);

  logic in_window;
  logic in_priv;
  logic priv_ok;

  // Window is [MEM_BASE, MEM_END)
  assign in_window = (i_req.addr >= MEM_BASE) && (i_req.addr < MEM_END);

  // Only meaningful inside the window
  assign in_priv = (i_req.addr >= MEM_PRIV_BASE);

  // prot[0] set means privileged access
  assign priv_ok = i_req.prot[0];

  // ------------------------------
  // Response select
  // ------------------------------
  always_comb begin
    o_dec.idx = i_req.addr[MEM_IDX_W+BYTE_OFF_W-1:BYTE_OFF_W];
    if (!in_window) begin
      o_dec.resp = DECERR;
    end else if (in_priv && !priv_ok) begin
      o_dec.resp = SLVERR;
    end else begin
      o_dec.resp = OKAY;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axil_mem_ctrl.sv
// AXI4-Lite write and read channel FSMs; drive handshakes, responses and the SRAM bank controls
`timescale 1ns/1ps
`default_nettype none

module axil_mem_ctrl import axil_mem_pkg::*; (
  input  wire logic                 i_aclk,
  input  wire logic                 i_rst,
  // Handshake inputs from the master
  input  wire logic                 i_awvalid,
  input  wire logic                 i_wvalid,
  input  wire logic                 i_bready,
  input  wire logic                 i_arvalid,
  input  wire logic                 i_rready,
  // Decode results from the two checkers
  input  wire addr_dec_t            i_wr_dec,
  input  wire addr_dec_t            i_rd_dec,
  // Handshake outputs
  output logic                      o_awready,
  output logic                      o_wready,
  output logic                      o_bvalid,
  output logic                      o_arready,
  output logic                      o_rvalid,
  output axil_resp_e                o_bresp,
  output axil_resp_e                o_rresp,
  // SRAM bank controls
  output logic                      o_wr_en,
  output logic      [MEM_IDX_W-1:0] o_wr_idx,
  output logic                      o_rd_en,
  output logic                      o_rd_zero
);

  wr_state_e  wr_state_q;
  wr_state_e  wr_state_d;
  rd_state_e  rd_state_q;
  rd_state_e  rd_state_d;
  addr_dec_t  wr_dec_q;
  axil_resp_e rd_resp_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid  & o_wready;
  assign b_fire  = o_bvalid  & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid  & i_rready;

  // ------------------------------
  // Write channel
  // ------------------------------
  assign o_awready = (wr_state_q == WR_IDLE);
  assign o_wready  = (wr_state_q == WR_WAIT_DATA);
  assign o_bvalid  = (wr_state_q == WR_RESP);
  assign o_bresp   = wr_dec_q.resp;

  // Memory is written on the W beat, at the index latched with AW
  assign o_wr_en  = w_fire && (wr_dec_q.resp == OKAY);
  assign o_wr_idx = wr_dec_q.idx;

  always_comb begin
    wr_state_d = wr_state_q;
    unique case (wr_state_q)
      WR_IDLE: begin
        if (aw_fire) begin
          wr_state_d = WR_WAIT_DATA;
        end
      end
      WR_WAIT_DATA: begin
        if (w_fire) begin
          wr_state_d = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_fire) begin
          wr_state_d = WR_IDLE;
        end
      end
      default: wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state_q <= WR_IDLE;
    end else begin
      wr_state_q <= wr_state_d;
    end
  end

  // Decode held through data and response phases
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_dec_q <= i_wr_dec;
    end
  end

  // ------------------------------
  // Read channel
  // ------------------------------
  assign o_arready = (rd_state_q == RD_IDLE);
  assign o_rvalid  = (rd_state_q == RD_RESP);
  assign o_rresp   = rd_resp_q;

  // Bank loads on AR fire; refused reads load zero
  assign o_rd_en   = ar_fire;
  assign o_rd_zero = (i_rd_dec.resp != OKAY);

  always_comb begin
    rd_state_d = rd_state_q;
    unique case (rd_state_q)
      RD_IDLE: begin
        if (ar_fire) begin
          rd_state_d = RD_RESP;
        end
      end
      RD_RESP: begin
        if (r_fire) begin
          rd_state_d = RD_IDLE;
        end
      end
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state_q <= RD_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_resp_q <= i_rd_dec.resp;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axil_mem_pkg.sv
// Shared widths, memory map, enums and channel structs; imported by every data memory module
`default_nettype none

package axil_mem_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 64;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int AXIL_PROT_W = 3;

  // ------------------------------
  // Memory map
  // ------------------------------
  localparam int MEM_WORDS  = 256;
  localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
  // Byte offset bits inside one 64-bit word
  localparam int BYTE_OFF_W = $clog2(AXIL_STRB_W);

  localparam logic [AXIL_ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
  // First byte past the window (2 KiB of SRAM)
  localparam logic [AXIL_ADDR_W-1:0] MEM_END =
    MEM_BASE + AXIL_ADDR_W'(MEM_WORDS * AXIL_STRB_W);
  // Top quarter of the window needs privilege
  localparam logic [AXIL_ADDR_W-1:0] MEM_PRIV_BASE =
    MEM_BASE + AXIL_ADDR_W'((3 * MEM_WORDS * AXIL_STRB_W) / 4);

  // ------------------------------
  // Enums
  // ------------------------------
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic [0:0] {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  // ------------------------------
  // Channel structs
  // ------------------------------
  // AW and AR payload
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_PROT_W-1:0] prot;
  } axil_req_t;

  // W payload
  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } axil_wbeat_t;

  // Decoded word index plus the response it earns
  typedef struct packed {
    logic [MEM_IDX_W-1:0] idx;
    axil_resp_e           resp;
  } addr_dec_t;

endpackage

`default_nettype wire

// File: rtl/axil_mem_top.sv
// Top level of the AXI4-Lite data memory; joins the slave ports to control, checkers and SRAM
`timescale 1ns/1ps
`default_nettype none

module axil_mem_top import axil_mem_pkg::*; (
  input  wire logic                   i_aclk,
  input  wire logic                   i_rst,
  // Write address
  input  wire logic                   i_awvalid,
  output logic                        o_awready,
  input  wire logic [AXIL_ADDR_W-1:0] i_awaddr,
  input  wire logic [AXIL_PROT_W-1:0] i_awprot,
  // Write data
  input  wire logic                   i_wvalid,
  output logic                        o_wready,
  input  wire logic [AXIL_DATA_W-1:0] i_wdata,
  input  wire logic [AXIL_STRB_W-1:0] i_wstrb,
  // Write response
  output logic                        o_bvalid,
  input  wire logic                   i_bready,
  output logic      [1:0]             o_bresp,
  // Read address
  input  wire logic                   i_arvalid,
  output logic                        o_arready,
  input  wire logic [AXIL_ADDR_W-1:0] i_araddr,
  input  wire logic [AXIL_PROT_W-1:0] i_arprot,
  // Read data
  output logic                        o_rvalid,
  input  wire logic                   i_rready,
  output logic      [AXIL_DATA_W-1:0] o_rdata,
  output logic      [1:0]             o_rresp
);

  axil_req_t            aw_req;
  axil_req_t            ar_req;
  axil_wbeat_t          wbeat;
  addr_dec_t            wr_dec;
  addr_dec_t            rd_dec;
  logic                 wr_en;
  logic [MEM_IDX_W-1:0] wr_idx;
  logic                 rd_en;
  logic                 rd_zero;

  // Flat bus signals into channel structs
  assign aw_req = '{addr: i_awaddr, prot: i_awprot};
  assign ar_req = '{addr: i_araddr, prot: i_arprot};
  assign wbeat  = '{data: i_wdata, strb: i_wstrb};

  axil_addr_check u_wr_check (
    .i_req (aw_req),
    .o_dec (wr_dec)
  );

  axil_addr_check u_rd_check (
    .i_req (ar_req),
    .o_dec (rd_dec)
  );

  axil_mem_ctrl u_ctrl (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_awvalid (i_awvalid),
    .i_wvalid  (i_wvalid),
    .i_bready  (i_bready),
    .i_arvalid (i_arvalid),
    .i_rready  (i_rready),
    .i_wr_dec  (wr_dec),
    .i_rd_dec  (rd_dec),
    .o_awready (o_awready),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .o_bresp   (o_bresp),
    .o_rresp   (o_rresp),
    .o_wr_en   (wr_en),
    .o_wr_idx  (wr_idx),
    .o_rd_en   (rd_en),
    .o_rd_zero (rd_zero)
  );

  // Read index comes straight from the AR decode
  axil_sram_bank u_bank (
    .i_aclk    (i_aclk),
    .i_wr_en   (wr_en),
    .i_wr_idx  (wr_idx),
    .i_wbeat   (wbeat),
    .i_rd_en   (rd_en),
    .i_rd_zero (rd_zero),
    .i_rd_idx  (rd_dec.idx),
    .o_rdata   (o_rdata)
  );

endmodule

`default_nettype wire

// File: rtl/axil_sram_bank.sv
// 256 x 64 SRAM with byte-strobe writes and a registered read port that can load zero
`timescale 1ns/1ps
`default_nettype none

module axil_sram_bank import axil_mem_pkg::*; (
  input  wire logic                   i_aclk,
  // Write port
  input  wire logic                   i_wr_en,
  input  wire logic [MEM_IDX_W-1:0]   i_wr_idx,
  input  wire axil_wbeat_t            i_wbeat,
  // Read port
  input  wire logic                   i_rd_en,
  input  wire logic                   i_rd_zero,
  input  wire logic [MEM_IDX_W-1:0]   i_rd_idx,
  output logic      [AXIL_DATA_W-1:0] o_rdata
);

  logic [AXIL_DATA_W-1:0] mem [MEM_WORDS];

  // ------------------------------
  // Write, merged byte by byte
  // ------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (i_wbeat.strb[b]) begin
          mem[i_wr_idx][b*8 +: 8] <= i_wbeat.data[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read register
  // ------------------------------
  // Same-edge write to the same word is not visible here, old data wins
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      if (i_rd_zero) begin
        o_rdata <= '0;
      end else begin
        o_rdata <= mem[i_rd_idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AXI4-Lite data memory testbench with Verilator and run it.
# Exit status is 0 only when the simulation log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=axil_mem_sim

verilator --binary --timing --assert -j 0 \
  --top-module axil_mem_tb \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f axil_mem_top.f > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$SIM_LOG"; then
  exit 0
fi
exit 1
